//--- verilog/isa_pkg.sv
package isa_pkg;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // one instruction word, two field layouts
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    // nine operations need a fourth bit
    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LW,
        MEM_LH,
        MEM_LHU,
        MEM_LB,
        MEM_LBU,
        MEM_SW,
        MEM_SH,
        MEM_SB
    } mem_op_e;

    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_ADEL = 5'd4,   // load address error
        EXC_ADES = 5'd5,   // store address error
        EXC_RI   = 5'd10,  // reserved instruction
        EXC_OV   = 5'd12   // integer overflow
    } exc_code_e;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LB      = 6'h20;
    localparam logic [5:0] OP_LH      = 6'h21;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_LBU     = 6'h24;
    localparam logic [5:0] OP_LHU     = 6'h25;
    localparam logic [5:0] OP_SB      = 6'h28;
    localparam logic [5:0] OP_SH      = 6'h29;
    localparam logic [5:0] OP_SW      = 6'h2b;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

endpackage

//--- verilog/pipe_pkg.sv
package pipe_pkg;

    // alu src2 select
    localparam logic [1:0] SRC2_REG  = 2'd0;
    localparam logic [1:0] SRC2_ZIMM = 2'd1;
    localparam logic [1:0] SRC2_SIMM = 2'd2;

    typedef struct packed {
        isa_pkg::alu_op_e   alu_op;
        logic               src1_is_sa;  // shift amount from imm[10:6]
        logic [1:0]         src2_sel;
        logic               trap_ov;
        isa_pkg::mem_op_e   mem_op;
        logic               gr_we;
        logic [4:0]         dest;
        logic [15:0]        imm;
        logic [31:0]        rs_value;
        logic [31:0]        rt_value;
        logic [31:0]        pc;
        logic               exc;
        isa_pkg::exc_code_e exc_code;
    } ds_to_es_t;

    typedef enum logic [1:0] {
        WB_REG,
        WB_STORE,
        WB_LOAD,
        WB_EXC
    } wb_kind_e;

    typedef struct packed {
        wb_kind_e           kind;
        logic [4:0]         dest;
        logic [31:0]        result;
        logic [3:0]         wen;
        logic [31:0]        wdata;
        isa_pkg::mem_op_e   mem_op;
        isa_pkg::exc_code_e exc_code;
        logic [31:0]        pc;
        logic [31:0]        addr;  // data address, zero for non-memory ops
    } es_to_rs_t;

    typedef struct packed {
        wb_kind_e           kind;
        logic [4:0]         dest;
        logic [31:0]        value;
        logic [3:0]         wen;
        isa_pkg::exc_code_e exc_code;
        logic [31:0]        pc;
    } wb_rec_t;

endpackage

//--- verilog/alu.sv
`timescale 1ns/1ns

module alu (
    input  isa_pkg::alu_op_e alu_op,
    input  logic [31:0]      src1,
    input  logic [31:0]      src2,
    output logic [31:0]      result,
    output logic             overflow
);
    import isa_pkg::*;

    logic        sub_op;    // subtract, or compare via subtract
    logic [31:0] src2_adj;
    logic [31:0] sum;
    logic        carry;
    logic        raw_ov;

    always_comb begin
        sub_op             = alu_op inside {ALU_SUB, ALU_SLT, ALU_SLTU};
        src2_adj           = sub_op ? ~src2 : src2;
        {carry, sum}       = {1'b0, src1} + {1'b0, src2_adj} + {32'd0, sub_op};
        raw_ov             = (src1[31] == src2_adj[31]) && (sum[31] != src1[31]);
        overflow           = raw_ov && (alu_op inside {ALU_ADD, ALU_SUB});

        case (alu_op)
            ALU_ADD,
            ALU_SUB:  result = sum;
            ALU_AND:  result = src1 & src2;
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_SLT:  result = {31'd0, sum[31] ^ raw_ov};  // sign corrected on overflow
            ALU_SLTU: result = {31'd0, !carry};            // borrow out
            ALU_SLL:  result = src2 << src1[4:0];
            ALU_SRL:  result = src2 >> src1[4:0];
            ALU_SRA:  result = $signed(src2) >>> src1[4:0];
            ALU_LUI:  result = {src2[15:0], 16'd0};
            default:  result = 32'd0;
        endcase
    end

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                in_valid,
    input  isa_pkg::inst_u      in_inst,
    input  logic [31:0]         in_rs_value,
    input  logic [31:0]         in_rt_value,
    input  logic [31:0]         in_pc,
    output logic                in_allowin,
    output logic                ds_valid,
    output pipe_pkg::ds_to_es_t ds_bus,
    input  logic                es_allowin
);
    import isa_pkg::*;
    import pipe_pkg::*;

    inst_u       inst_r;
    logic [31:0] rs_value_r;
    logic [31:0] rt_value_r;
    logic [31:0] pc_r;
    logic        known;  // opcode and funct recognized

    assign in_allowin = !ds_valid || es_allowin;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ds_valid <= 1'b0;
        end else if (in_allowin) begin
            ds_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            inst_r     <= in_inst;
            rs_value_r <= in_rs_value;
            rt_value_r <= in_rt_value;
            pc_r       <= in_pc;
        end
    end

    always_comb begin
        ds_bus          = '0;
        ds_bus.alu_op   = ALU_ADD;
        ds_bus.mem_op   = MEM_NONE;
        ds_bus.exc_code = EXC_NONE;
        ds_bus.imm      = inst_r.i.imm;
        ds_bus.rs_value = rs_value_r;
        ds_bus.rt_value = rt_value_r;
        ds_bus.pc       = pc_r;
        ds_bus.gr_we    = 1'b1;
        known           = 1'b1;

        if (inst_r.r.opcode == OP_SPECIAL) begin
            ds_bus.dest     = inst_r.r.rd;
            ds_bus.src2_sel = SRC2_REG;
            case (inst_r.r.funct)
                FN_ADD, FN_ADDU: ds_bus.alu_op = ALU_ADD;
                FN_SUB, FN_SUBU: ds_bus.alu_op = ALU_SUB;
                FN_AND:          ds_bus.alu_op = ALU_AND;
                FN_OR:           ds_bus.alu_op = ALU_OR;
                FN_XOR:          ds_bus.alu_op = ALU_XOR;
                FN_NOR:          ds_bus.alu_op = ALU_NOR;
                FN_SLT:          ds_bus.alu_op = ALU_SLT;
                FN_SLTU:         ds_bus.alu_op = ALU_SLTU;
                FN_SLL:          ds_bus.alu_op = ALU_SLL;
                FN_SRL:          ds_bus.alu_op = ALU_SRL;
                FN_SRA:          ds_bus.alu_op = ALU_SRA;
                default:         known = 1'b0;
            endcase
            ds_bus.src1_is_sa = inst_r.r.funct inside {FN_SLL, FN_SRL, FN_SRA};
            ds_bus.trap_ov    = inst_r.r.funct inside {FN_ADD, FN_SUB};
        end else begin
            ds_bus.dest     = inst_r.i.rt;
            ds_bus.src2_sel = SRC2_SIMM;  // loads and stores add the offset
            case (inst_r.i.opcode)
                OP_ADDI, OP_ADDIU: ds_bus.alu_op = ALU_ADD;
                OP_SLTI:           ds_bus.alu_op = ALU_SLT;
                OP_SLTIU:          ds_bus.alu_op = ALU_SLTU;
                OP_ANDI:           ds_bus.alu_op = ALU_AND;
                OP_ORI:            ds_bus.alu_op = ALU_OR;
                OP_XORI:           ds_bus.alu_op = ALU_XOR;
                OP_LUI:            ds_bus.alu_op = ALU_LUI;
                OP_LW:             ds_bus.mem_op = MEM_LW;
                OP_LH:             ds_bus.mem_op = MEM_LH;
                OP_LHU:            ds_bus.mem_op = MEM_LHU;
                OP_LB:             ds_bus.mem_op = MEM_LB;
                OP_LBU:            ds_bus.mem_op = MEM_LBU;
                OP_SW:             ds_bus.mem_op = MEM_SW;
                OP_SH:             ds_bus.mem_op = MEM_SH;
                OP_SB:             ds_bus.mem_op = MEM_SB;
                default:           known = 1'b0;
            endcase
            if (inst_r.i.opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI}) begin
                ds_bus.src2_sel = SRC2_ZIMM;
            end
            ds_bus.trap_ov = (inst_r.i.opcode == OP_ADDI);
            if (ds_bus.mem_op inside {MEM_SW, MEM_SH, MEM_SB}) begin
                ds_bus.gr_we = 1'b0;  // stores write no register
                ds_bus.dest  = 5'd0;
            end
        end

        if (!known) begin
            ds_bus.exc      = 1'b1;
            ds_bus.exc_code = EXC_RI;
            ds_bus.gr_we    = 1'b0;
            ds_bus.dest     = 5'd0;
            ds_bus.trap_ov  = 1'b0;
        end
    end

    // execute may stall us; the offered word must not move
    ds_bus_hold: assert property (@(posedge clk) disable iff (reset)
        ds_valid && !es_allowin && !flush |=> $stable(ds_bus));

endmodule

//--- verilog/exe_stage.sv
`timescale 1ns/1ns

module exe_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                ds_valid,
    input  pipe_pkg::ds_to_es_t ds_bus,
    output logic                es_allowin,
    output logic                es_valid,
    output pipe_pkg::es_to_rs_t es_bus,
    input  logic                rs_allowin
);
    import isa_pkg::*;
    import pipe_pkg::*;

    ds_to_es_t   bus_r;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] alu_result;  // also the data address
    logic        overflow;
    logic        ov_ex;
    logic        ades_ex;
    logic        adel_ex;
    logic        any_exc;
    logic        is_store;
    logic        is_load;
    logic [3:0]  wen;
    logic [31:0] wdata;
    exc_code_e   exc_code;

    assign es_allowin = !es_valid || rs_allowin;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_valid && es_allowin) begin
            bus_r <= ds_bus;
        end
    end

    assign src1 = bus_r.src1_is_sa ? {27'd0, bus_r.imm[10:6]} : bus_r.rs_value;

    always_comb begin
        case (bus_r.src2_sel)
            SRC2_ZIMM: src2 = {16'd0, bus_r.imm};
            SRC2_SIMM: src2 = {{16{bus_r.imm[15]}}, bus_r.imm};
            default:   src2 = bus_r.rt_value;
        endcase
    end

    alu u_alu (
        .alu_op   (bus_r.alu_op),
        .src1     (src1),
        .src2     (src2),
        .result   (alu_result),
        .overflow (overflow)
    );

    assign is_store = bus_r.mem_op inside {MEM_SW, MEM_SH, MEM_SB};
    assign is_load  = bus_r.mem_op inside {MEM_LW, MEM_LH, MEM_LHU, MEM_LB, MEM_LBU};

    // byte lanes and replicated store data
    always_comb begin
        wen   = 4'b0000;
        wdata = 32'd0;
        case (bus_r.mem_op)
            MEM_SB: begin
                wen   = 4'b0001 << alu_result[1:0];
                wdata = {4{bus_r.rt_value[7:0]}};
            end
            MEM_SH: begin
                wen   = alu_result[1] ? 4'b1100 : 4'b0011;
                wdata = {2{bus_r.rt_value[15:0]}};
            end
            MEM_SW: begin
                wen   = 4'b1111;
                wdata = bus_r.rt_value;
            end
            default: begin
                wen   = 4'b0000;
                wdata = 32'd0;
            end
        endcase
    end

    assign ov_ex   = bus_r.trap_ov && overflow;
    assign ades_ex = (bus_r.mem_op == MEM_SH && alu_result[0])
                  || (bus_r.mem_op == MEM_SW && |alu_result[1:0]);
    assign adel_ex = (bus_r.mem_op inside {MEM_LH, MEM_LHU} && alu_result[0])
                  || (bus_r.mem_op == MEM_LW && |alu_result[1:0]);
    assign any_exc = bus_r.exc || ov_ex || ades_ex || adel_ex;

    always_comb begin
        if (bus_r.exc) begin
            exc_code = bus_r.exc_code;  // decode fault wins
        end else if (ov_ex) begin
            exc_code = EXC_OV;
        end else if (ades_ex) begin
            exc_code = EXC_ADES;
        end else if (adel_ex) begin
            exc_code = EXC_ADEL;
        end else begin
            exc_code = EXC_NONE;
        end
    end

    always_comb begin
        es_bus          = '0;
        es_bus.kind     = any_exc ? WB_EXC : is_store ? WB_STORE : is_load ? WB_LOAD : WB_REG;
        es_bus.dest     = bus_r.gr_we ? bus_r.dest : 5'd0;
        es_bus.result   = alu_result;
        es_bus.wen      = wen;
        es_bus.wdata    = wdata;
        es_bus.mem_op   = bus_r.mem_op;
        es_bus.exc_code = exc_code;
        es_bus.pc       = bus_r.pc;
        es_bus.addr     = (is_store || is_load) ? alu_result : 32'd0;
    end

    // decode's exc flag and code must agree with what reaches here
    exc_kind_match: assert property (@(posedge clk) disable iff (reset)
        es_valid |-> ((es_bus.exc_code == EXC_NONE) == (es_bus.kind != WB_EXC)));

endmodule

//--- verilog/result_stage.sv
`timescale 1ns/1ns

module result_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                es_valid,
    input  pipe_pkg::es_to_rs_t es_bus,
    output logic                rs_allowin,
    output logic                out_valid,
    output pipe_pkg::wb_rec_t   out_rec,
    output logic [31:0]         out_addr,
    input  logic                out_allowin
);
    import pipe_pkg::*;

    es_to_rs_t bus_r;

    assign rs_allowin = !out_valid || out_allowin;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out_valid <= 1'b0;
        end else if (rs_allowin) begin
            out_valid <= es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_valid && rs_allowin) begin
            bus_r <= es_bus;
        end
    end

    always_comb begin
        out_rec          = '0;
        out_rec.kind     = bus_r.kind;
        out_rec.exc_code = bus_r.exc_code;
        out_rec.pc       = bus_r.pc;
        case (bus_r.kind)
            WB_REG: begin
                out_rec.dest  = bus_r.dest;
                out_rec.value = bus_r.result;
            end
            WB_STORE: begin
                out_rec.value = bus_r.wdata;
                out_rec.wen   = bus_r.wen;
            end
            WB_LOAD: out_rec.dest = bus_r.dest;  // data returns from memory
            default: out_rec.value = 32'd0;      // exception keeps only code and pc
        endcase
    end

    assign out_addr = bus_r.addr;

    out_rec_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_allowin && !flush |=> $stable(out_rec) && $stable(out_addr));

endmodule

//--- verilog/exe_subsys_top.sv
`timescale 1ns/1ns

module exe_subsys_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              in_valid,
    input  isa_pkg::inst_u    in_inst,
    input  logic [31:0]       in_rs_value,
    input  logic [31:0]       in_rt_value,
    input  logic [31:0]       in_pc,
    output logic              in_allowin,
    output logic              out_valid,
    output pipe_pkg::wb_rec_t out_rec,
    output logic [31:0]       out_addr,
    input  logic              out_allowin
);
    import pipe_pkg::*;

    logic      ds_valid;
    ds_to_es_t ds_bus;
    logic      es_allowin;
    logic      es_valid;
    es_to_rs_t es_bus;
    logic      rs_allowin;

    decode_stage u_decode (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_inst     (in_inst),
        .in_rs_value (in_rs_value),
        .in_rt_value (in_rt_value),
        .in_pc       (in_pc),
        .in_allowin  (in_allowin),
        .ds_valid    (ds_valid),
        .ds_bus      (ds_bus),
        .es_allowin  (es_allowin)
    );

    exe_stage u_exe (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .ds_valid   (ds_valid),
        .ds_bus     (ds_bus),
        .es_allowin (es_allowin),
        .es_valid   (es_valid),
        .es_bus     (es_bus),
        .rs_allowin (rs_allowin)
    );

    result_stage u_result (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .es_valid    (es_valid),
        .es_bus      (es_bus),
        .rs_allowin  (rs_allowin),
        .out_valid   (out_valid),
        .out_rec     (out_rec),
        .out_addr    (out_addr),
        .out_allowin (out_allowin)
    );

endmodule

//--- verif/exe_subsys_tb.sv
`timescale 1ns/1ns

module exe_subsys_tb;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int MAX_ROWS   = 40;
    localparam int WAIT_LIMIT = 50;  // cycles to wait for in_allowin
    localparam int IDLE_LIMIT = 60;  // cycles without an output transfer

    logic        clk;
    logic        reset;
    logic        flush;
    logic        in_valid;
    inst_u       in_inst;
    logic [31:0] in_rs_value;
    logic [31:0] in_rt_value;
    logic [31:0] in_pc;
    logic        in_allowin;
    logic        out_valid;
    wb_rec_t     out_rec;
    logic [31:0] out_addr;
    logic        out_allowin;

    string       name_tab[MAX_ROWS];
    logic [31:0] inst_tab[MAX_ROWS];
    logic [31:0] rs_tab[MAX_ROWS];
    logic [31:0] rt_tab[MAX_ROWS];
    logic [31:0] pc_tab[MAX_ROWS];
    wb_rec_t     rec_tab[MAX_ROWS];
    logic [31:0] addr_tab[MAX_ROWS];
    int          n_rows;
    int          n_main;      // rows before the flush phase
    int          pass_count;
    int          fail_count;
    int          error_count; // stall, flush and state errors

    exe_subsys_top DUT (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_inst     (in_inst),
        .in_rs_value (in_rs_value),
        .in_rt_value (in_rt_value),
        .in_pc       (in_pc),
        .in_allowin  (in_allowin),
        .out_valid   (out_valid),
        .out_rec     (out_rec),
        .out_addr    (out_addr),
        .out_allowin (out_allowin)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] r_word(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] shamt,
                                           input logic [5:0] funct);
        return {OP_SPECIAL, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wb_rec_t reg_rec(input logic [4:0] dest, input logic [31:0] value);
        wb_rec_t rec;
        rec       = '0;
        rec.kind  = WB_REG;
        rec.dest  = dest;
        rec.value = value;
        return rec;
    endfunction

    function automatic wb_rec_t store_rec(input logic [3:0] wen, input logic [31:0] wdata);
        wb_rec_t rec;
        rec       = '0;
        rec.kind  = WB_STORE;
        rec.wen   = wen;
        rec.value = wdata;  // replicated store data
        return rec;
    endfunction

    function automatic wb_rec_t load_rec(input logic [4:0] dest);
        wb_rec_t rec;
        rec      = '0;
        rec.kind = WB_LOAD;
        rec.dest = dest;
        return rec;
    endfunction

    function automatic wb_rec_t exc_rec(input exc_code_e code);
        wb_rec_t rec;
        rec          = '0;
        rec.kind     = WB_EXC;
        rec.exc_code = code;
        return rec;
    endfunction

    // pc is assigned here, one word per row
    task automatic add_row(input string name, input logic [31:0] inst, input logic [31:0] rs_v,
                           input logic [31:0] rt_v, input wb_rec_t rec, input logic [31:0] addr);
        logic [31:0] pc;
        pc                = 32'h0040_0000 + 32'(4 * n_rows);
        name_tab[n_rows]  = name;
        inst_tab[n_rows]  = inst;
        rs_tab[n_rows]    = rs_v;
        rt_tab[n_rows]    = rt_v;
        pc_tab[n_rows]    = pc;
        rec_tab[n_rows]   = rec;
        rec_tab[n_rows].pc = pc;
        addr_tab[n_rows]  = addr;
        n_rows++;
    endtask

    // called just after a rising edge; returns just after the accepting edge
    task automatic send_item(input logic [31:0] inst, input logic [31:0] rs_v,
                             input logic [31:0] rt_v, input logic [31:0] pc);
        int waited;
        in_valid    = 1'b1;
        in_inst     = inst;
        in_rs_value = rs_v;
        in_rt_value = rt_v;
        in_pc       = pc;
        waited      = 0;
        @(negedge clk);
        while (!in_allowin && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!in_allowin) begin
            error_count++;
            $display("input with pc %h was not accepted within %0d cycles",
                     pc, WAIT_LIMIT);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic send_row(input int idx);
        send_item(inst_tab[idx], rs_tab[idx], rt_tab[idx], pc_tab[idx]);
    endtask

    task automatic check_row(input int idx);
        assert (out_rec === rec_tab[idx] && out_addr === addr_tab[idx]) begin
            pass_count++;
            $display("ok    %s", name_tab[idx]);
        end else begin
            fail_count++;
            $display("** Error %s: expected rec %h addr %h, actual rec %h addr %h",
                     name_tab[idx], rec_tab[idx], addr_tab[idx], out_rec, out_addr);
        end
    endtask

    // random out_allowin stalls, in-order compare, hold check while stalled
    task automatic collect_outputs(input int first, input int last);
        int          idx;
        int          idle;
        logic        held;
        wb_rec_t     held_rec;
        logic [31:0] held_addr;
        idx       = first;
        idle      = 0;
        held      = 1'b0;
        held_rec  = '0;
        held_addr = 32'd0;
        while (idx < last && idle < IDLE_LIMIT) begin
            @(posedge clk);
            #1;
            out_allowin = ($urandom % 4) != 0;  // stall about one cycle in four
            @(negedge clk);
            if (held) begin
                assert (out_valid && out_rec === held_rec && out_addr === held_addr)
                else begin
                    error_count++;
                    $display("output for %s changed or vanished while stalled",
                             name_tab[idx]);
                end
            end
            held      = out_valid && !out_allowin;
            held_rec  = out_rec;
            held_addr = out_addr;
            if (out_valid && out_allowin) begin
                check_row(idx);
                idx++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (idx < last) begin
            error_count++;
            $display("no output arrived for %s within %0d cycles",
                     name_tab[idx], IDLE_LIMIT);
        end
    endtask

    task automatic build_table();
        add_row("add", r_word(5'd1, 5'd2, 5'd3, 5'd0, FN_ADD), 32'd5, 32'd7,
                reg_rec(5'd3, 32'd12), 32'd0);
        add_row("addu_no_trap", r_word(5'd1, 5'd2, 5'd4, 5'd0, FN_ADDU), 32'h7fff_ffff,
                32'd1, reg_rec(5'd4, 32'h8000_0000), 32'd0);
        add_row("add_overflow", r_word(5'd1, 5'd2, 5'd4, 5'd0, FN_ADD), 32'h7fff_ffff,
                32'd1, exc_rec(EXC_OV), 32'd0);
        add_row("sub", r_word(5'd1, 5'd2, 5'd5, 5'd0, FN_SUB), 32'd10, 32'd3,
                reg_rec(5'd5, 32'd7), 32'd0);
        add_row("subu", r_word(5'd1, 5'd2, 5'd6, 5'd0, FN_SUBU), 32'd3, 32'd10,
                reg_rec(5'd6, 32'hffff_fff9), 32'd0);
        add_row("and", r_word(5'd1, 5'd2, 5'd7, 5'd0, FN_AND), 32'hf0f0_f0f0, 32'hff00_ff00,
                reg_rec(5'd7, 32'hf000_f000), 32'd0);
        add_row("or", r_word(5'd1, 5'd2, 5'd8, 5'd0, FN_OR), 32'hf0f0_f0f0, 32'h0f0f_0000,
                reg_rec(5'd8, 32'hffff_f0f0), 32'd0);
        add_row("xor", r_word(5'd1, 5'd2, 5'd9, 5'd0, FN_XOR), 32'hffff_0000, 32'h0ff0_0ff0,
                reg_rec(5'd9, 32'hf00f_0ff0), 32'd0);
        add_row("nor", r_word(5'd1, 5'd2, 5'd10, 5'd0, FN_NOR), 32'h0000_ffff, 32'h00ff_0000,
                reg_rec(5'd10, 32'hff00_0000), 32'd0);
        add_row("slt_signed", r_word(5'd1, 5'd2, 5'd11, 5'd0, FN_SLT), 32'hffff_ffff, 32'd1,
                reg_rec(5'd11, 32'd1), 32'd0);
        add_row("sltu_unsigned", r_word(5'd1, 5'd2, 5'd12, 5'd0, FN_SLTU), 32'hffff_ffff,
                32'd1, reg_rec(5'd12, 32'd0), 32'd0);
        add_row("sll", r_word(5'd0, 5'd2, 5'd13, 5'd4, FN_SLL), 32'hdead_beef, 32'd1,
                reg_rec(5'd13, 32'h10), 32'd0);
        add_row("srl", r_word(5'd0, 5'd2, 5'd14, 5'd31, FN_SRL), 32'd0, 32'h8000_0000,
                reg_rec(5'd14, 32'd1), 32'd0);
        add_row("sra", r_word(5'd0, 5'd2, 5'd15, 5'd4, FN_SRA), 32'd0, 32'h8000_0000,
                reg_rec(5'd15, 32'hf800_0000), 32'd0);
        add_row("addi_sign_ext", i_word(OP_ADDI, 5'd1, 5'd16, 16'hfffc), 32'h100, 32'd0,
                reg_rec(5'd16, 32'hfc), 32'd0);
        add_row("addiu", i_word(OP_ADDIU, 5'd1, 5'd17, 16'h8000), 32'h10, 32'd0,
                reg_rec(5'd17, 32'hffff_8010), 32'd0);
        add_row("andi", i_word(OP_ANDI, 5'd1, 5'd18, 16'h8001), 32'hffff_ffff, 32'd0,
                reg_rec(5'd18, 32'h0000_8001), 32'd0);
        add_row("ori_zero_ext", i_word(OP_ORI, 5'd1, 5'd19, 16'h8000), 32'h1234_0000, 32'd0,
                reg_rec(5'd19, 32'h1234_8000), 32'd0);
        add_row("xori", i_word(OP_XORI, 5'd1, 5'd20, 16'h00ff), 32'h0000_ffff, 32'd0,
                reg_rec(5'd20, 32'h0000_ff00), 32'd0);
        add_row("slti", i_word(OP_SLTI, 5'd1, 5'd21, 16'hffff), 32'hffff_fffe, 32'd0,
                reg_rec(5'd21, 32'd1), 32'd0);
        add_row("sltiu", i_word(OP_SLTIU, 5'd1, 5'd22, 16'hffff), 32'd5, 32'd0,
                reg_rec(5'd22, 32'd1), 32'd0);
        add_row("lui", i_word(OP_LUI, 5'd0, 5'd23, 16'habcd), 32'h55, 32'd0,
                reg_rec(5'd23, 32'habcd_0000), 32'd0);
        add_row("sb_off0", i_word(OP_SB, 5'd1, 5'd2, 16'd0), 32'h2000, 32'h1122_3344,
                store_rec(4'b0001, 32'h4444_4444), 32'h2000);
        add_row("sb_off1", i_word(OP_SB, 5'd1, 5'd2, 16'd1), 32'h2000, 32'h1122_3344,
                store_rec(4'b0010, 32'h4444_4444), 32'h2001);
        add_row("sb_off2", i_word(OP_SB, 5'd1, 5'd2, 16'd2), 32'h2000, 32'h1122_3344,
                store_rec(4'b0100, 32'h4444_4444), 32'h2002);
        add_row("sb_off3", i_word(OP_SB, 5'd1, 5'd2, 16'd3), 32'h2000, 32'h1122_3344,
                store_rec(4'b1000, 32'h4444_4444), 32'h2003);
        add_row("sh_off0", i_word(OP_SH, 5'd1, 5'd2, 16'd0), 32'h2000, 32'h1122_3344,
                store_rec(4'b0011, 32'h3344_3344), 32'h2000);
        add_row("sh_off2", i_word(OP_SH, 5'd1, 5'd2, 16'd2), 32'h2000, 32'h1122_3344,
                store_rec(4'b1100, 32'h3344_3344), 32'h2002);
        add_row("sw", i_word(OP_SW, 5'd1, 5'd2, 16'd0), 32'h2000, 32'h1122_3344,
                store_rec(4'b1111, 32'h1122_3344), 32'h2000);
        add_row("sw_ades", i_word(OP_SW, 5'd1, 5'd2, 16'd2), 32'h2000, 32'h1122_3344,
                exc_rec(EXC_ADES), 32'h2002);
        add_row("lh_adel", i_word(OP_LH, 5'd1, 5'd24, 16'd1), 32'h2000, 32'd0,
                exc_rec(EXC_ADEL), 32'h2001);
        add_row("lw_aligned", i_word(OP_LW, 5'd1, 5'd24, 16'd4), 32'h2000, 32'd0,
                load_rec(5'd24), 32'h2004);
        add_row("ri_opcode", i_word(6'h3f, 5'd1, 5'd2, 16'h1234), 32'd1, 32'd2,
                exc_rec(EXC_RI), 32'd0);
        add_row("ri_funct", r_word(5'd1, 5'd2, 5'd3, 5'd0, 6'h3f), 32'd1, 32'd2,
                exc_rec(EXC_RI), 32'd0);
        n_main = n_rows;
        add_row("addiu_after_flush", i_word(OP_ADDIU, 5'd1, 5'd25, 16'd1), 32'h7fff_ffff,
                32'd0, reg_rec(5'd25, 32'h8000_0000), 32'd0);
    endtask

    initial begin
        reset       = 1'b1;
        flush       = 1'b0;
        in_valid    = 1'b0;
        in_inst     = '0;
        in_rs_value = 32'd0;
        in_rt_value = 32'd0;
        in_pc       = 32'd0;
        out_allowin = 1'b1;
        n_rows      = 0;
        pass_count  = 0;
        fail_count  = 0;
        error_count = 0;
        void'($urandom(88));
        build_table();

        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        assert (!out_valid && in_allowin)
        else begin
            error_count++;
            $display("pipeline was not empty and ready after reset");
        end

        fork
            begin
                for (int i = 0; i < n_main; i++) begin
                    send_row(i);
                end
            end
            collect_outputs(0, n_main);
        join

        // fill all three stages with stalled items, then flush them
        @(posedge clk);
        #1;
        out_allowin = 1'b0;
        for (int v = 0; v < 3; v++) begin
            send_item(i_word(OP_ADDIU, 5'd1, 5'd26, 16'(v + 1)), 32'd100, 32'd0,
                      32'h00ff_0000 + 32'(4 * v));
        end
        assert (out_valid && !in_allowin)
        else begin
            error_count++;
            $display("three stalled items did not fill the pipeline before flush");
        end
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush       = 1'b0;
        out_allowin = 1'b1;
        repeat (4) begin
            @(negedge clk);
            assert (!out_valid)
            else begin
                error_count++;
                $display("a flushed item still produced an output record");
            end
        end
        @(posedge clk);
        #1;
        fork
            send_row(n_main);
            collect_outputs(n_main, n_main + 1);
        join

        $display("%0d tests passed, %0d tests failed, %0d other errors",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/alu.sv
verilog/decode_stage.sv
verilog/exe_stage.sv
verilog/result_stage.sv
verilog/exe_subsys_top.sv
verif/exe_subsys_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= exe_subsys_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then echo "run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
